// ==== gps_panel.f ====
+incdir+.
gps_panel_pkg.sv
panel_reset.sv
sample_clock_divider.sv
tracking_ready_stretch.sv
status_display_select.sv
hex_display.sv
gps_panel_top.sv
tb_gps_panel.sv

// ==== tb_gps_panel.sv ====
`timescale 1ns/100ps

module tb_gps_panel;

   localparam int CYCLE_LIMIT = 3000;   // Directed tests take about 370 cycles

   // Lit segments gfedcba for digits F down to 0
   localparam logic [111:0] LIT_SEGMENTS = {7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77, 7'h6f,
                                            7'h7f, 7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b,
                                            7'h06, 7'h3f};

   // Hex page switch settings with entry 0 in the low bits
   localparam logic [233:0] PAGE_SWITCHES = {18'h0d000, 18'h0d010, 18'h30000, 18'h20000,
                                             18'h10000, 18'h00000, 18'h08000, 18'h07000,
                                             18'h06000, 18'h05000, 18'h04000, 18'h00018,
                                             18'h00010};

   logic                           clk_16_8, reset, pll_locked, key_n, tracking_ready;
   logic                           system_reset, clk_sample, ready_flag;
   gps_panel_pkg::switch_t         sw;
   gps_panel_pkg::feed_status_t    feed;
   gps_panel_pkg::channel_status_t chan;
   gps_panel_pkg::acq_result_t     acq;
   logic [17:0]                    ledr;
   logic [8:0]                     ledg;
   gps_panel_pkg::seg_t [7:0]      hex;
   integer                         seed;
   int                             cycle_count, check_count, error_count;

   gps_panel_top u_gps_panel_top (.*);

   always #5 clk_16_8 = ~clk_16_8;

   always @(posedge clk_16_8) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic expect_ok(input logic ok, input string msg);
      check_count++;
      assert (ok) else begin
         error_count++;
         $display("FAILED %0t ns: %s", $time, msg);
      end
   endtask

   // Selected accumulator or prompt value
   function automatic logic [17:0] iq_value(input gps_panel_pkg::switch_t s);
      if (s[17]) begin
         return s[16] ? chan.acc_q : chan.acc_i;
      end
      return s[16] ? chan.q_prompt : chan.i_prompt;
   endfunction

   // Returns {digit values, digit enables}
   function automatic logic [39:0] expected_frame(input gps_panel_pkg::switch_t s);
      if (s[4]) begin
         return {(s[3] ? chan.sample_count_sync : feed.sample_count), 8'hff};
      end else if (s[14] && s[13:12] == 2'd1) begin
         return {15'd0, acq.peak_doppler, 8'h1f};
      end else if (s[14] && s[13:12] == 2'd2) begin
         return {17'd0, acq.peak_code_shift, 8'h0f};
      end else if (s[14]) begin
         return {acq.peak_i2q2[37:6], 8'hff};   // Sub-page 0 or 3
      end else if (s[15]) begin
         return {17'd0, chan.code_shift, 8'h0f};
      end
      return {14'd0, iq_value(s), 8'h1f};
   endfunction

   task automatic randomize_status();
      feed = {$random(seed), $random(seed)};
      chan = {$random(seed), $random(seed), $random(seed), $random(seed)};
      acq  = {$random(seed), $random(seed), $random(seed)};
   endtask

   task automatic check_reset();
      int held = 0;
      repeat (16) begin
         @(negedge clk_16_8);
         held += system_reset;
      end
      expect_ok(held == 16, $sformatf("system_reset high in %0d of 16 hold cycles", held));
      expect_ok(ledr == 0 && ledg == 0 && hex === '1, "LEDs or digits not cleared in reset");
      @(negedge clk_16_8);
      expect_ok(!system_reset, "system_reset still high after the power-on hold");
      pll_locked = 1'b0;
      repeat (2) @(negedge clk_16_8);
      expect_ok(system_reset, "system_reset not raised by loss of PLL lock");
      pll_locked = 1'b1;
      repeat (2) @(negedge clk_16_8);
      expect_ok(!system_reset, "system_reset not released after PLL relock");
      key_n = 1'b0;
      repeat (2) @(negedge clk_16_8);
      expect_ok(system_reset, "system_reset not raised by the reset key");
      key_n = 1'b1;
      repeat (2) @(negedge clk_16_8);
      expect_ok(!system_reset, "system_reset not released after the key was let go");
   endtask

   task automatic check_sample_clock();
      logic last;
      int   gap;
      last = clk_sample;
      while (clk_sample == last) begin   // Align to the first toggle
         @(negedge clk_16_8);
      end
      repeat (20) begin
         last = clk_sample;
         gap  = 0;
         while (clk_sample == last && gap < 20) begin
            @(negedge clk_16_8);
            gap++;
         end
         expect_ok(gap == 9, $sformatf("clk_sample toggled after %0d cycles, expected 9", gap));
      end
   endtask

   task automatic check_ready_stretch();
      int high = 0;
      sw[0]          = 1'b1;   // Tracking mode
      tracking_ready = 1'b1;
      @(negedge clk_16_8);
      tracking_ready = 1'b0;
      while (ready_flag && high < 40) begin
         high++;
         @(negedge clk_16_8);
      end
      expect_ok(high == 16, $sformatf("ready_flag high for %0d cycles, expected 16", high));
      sw[0]          = 1'b0;
      tracking_ready = 1'b1;
      @(negedge clk_16_8);
      tracking_ready = 1'b0;
      repeat (20) begin
         expect_ok(!ready_flag, "ready_flag raised by a pulse in acquisition mode");
         @(negedge clk_16_8);
      end
   endtask

   task automatic check_leds();
      logic [17:0] exp_ledr;
      logic [8:0]  exp_ledg;
      for (int k = 0; k < 16; k++) begin
         randomize_status();
         sw = {k[3:2], 4'd0, k[1:0], 10'd0};   // sw[17,16,11,10]
         repeat (2) @(negedge clk_16_8);
         exp_ledr = sw[11] ? {9'd0, (sw[10] ? feed.good_pkt_count : feed.missed_count)}
                           : iq_value(sw);
         exp_ledg    = '0;
         exp_ledg[8] = feed.link_status;
         exp_ledg[2] = acq.complete;
         exp_ledg[1] = feed.sample_valid;
         expect_ok(ledr === exp_ledr && ledg === exp_ledg,
                   $sformatf("sw=%05h gives ledr %05h ledg %03h, expected %05h %03h",
                             sw, ledr, ledg, exp_ledr, exp_ledg));
      end
   endtask

   task automatic check_hex_pages();
      logic [39:0] frm;
      logic [3:0]  nib;
      logic [6:0]  exp_seg;
      repeat (2) begin
         for (int p = 0; p < 13; p++) begin
            randomize_status();
            sw = PAGE_SWITCHES[18*p +: 18];
            repeat (3) @(negedge clk_16_8);
            frm = expected_frame(sw);
            for (int i = 0; i < 8; i++) begin
               nib     = frm[8 + 4*i +: 4];
               exp_seg = frm[i] ? ~LIT_SEGMENTS[7*nib +: 7] : 7'h7f;   // Blank when disabled
               expect_ok(hex[i] === exp_seg,
                         $sformatf("sw=%05h digit %0d shows %07b, expected %07b",
                                   sw, i, hex[i], exp_seg));
            end
         end
      end
   endtask

   initial begin
      seed           = 9;
      cycle_count    = 0;
      check_count    = 0;
      error_count    = 0;
      clk_16_8       = 1'b0;
      reset          = 1'b1;
      pll_locked     = 1'b1;
      key_n          = 1'b1;
      tracking_ready = 1'b0;
      sw             = '0;
      feed           = '1;
      chan           = '1;
      acq            = '1;
      repeat (10) @(negedge clk_16_8);
      reset = 1'b0;
      check_reset();
      check_sample_clock();
      check_ready_stretch();
      check_leds();
      check_hex_pages();
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== gps_panel_top.sv ====
`timescale 1ns/100ps

module gps_panel_top (
   input  logic                                clk_16_8,
   input  logic                                reset,
   input  logic                                pll_locked,
   input  logic                                key_n,
   input  gps_panel_pkg::switch_t              sw,
   input  gps_panel_pkg::feed_status_t         feed,
   input  gps_panel_pkg::channel_status_t      chan,
   input  gps_panel_pkg::acq_result_t          acq,
   input  logic                                tracking_ready,
   output logic                                system_reset,
   output logic                                clk_sample,
   output logic                                ready_flag,
   output logic [17:0]                         ledr,
   output logic [8:0]                          ledg,
   output gps_panel_pkg::seg_t           [7:0] hex
);

   gps_panel_pkg::hex_frame_t frame;

   panel_reset u_panel_reset (
      .clk_16_8     (clk_16_8),
      .reset        (reset),
      .pll_locked   (pll_locked),
      .key_n        (key_n),
      .system_reset (system_reset)
   );

   sample_clock_divider u_sample_clock_divider (
      .clk_16_8     (clk_16_8),
      .system_reset (system_reset),
      .clk_sample   (clk_sample)
   );

   tracking_ready_stretch u_tracking_ready_stretch (
      .clk_16_8       (clk_16_8),
      .system_reset   (system_reset),
      .tracking_ready (tracking_ready),
      .mode_track     (sw[0]),          // 1 = tracking, 0 = acquisition
      .ready_flag     (ready_flag)
   );

   status_display_select u_status_display_select (
      .clk_16_8     (clk_16_8),
      .system_reset (system_reset),
      .sw           (sw),
      .feed         (feed),
      .chan         (chan),
      .acq          (acq),
      .ledr         (ledr),
      .ledg         (ledg),
      .frame        (frame)
   );

   hex_display u_hex_display (
      .clk_16_8     (clk_16_8),
      .system_reset (system_reset),
      .frame        (frame),
      .hex          (hex)
   );

endmodule

// ==== hex_display.sv ====
`timescale 1ns/100ps

module hex_display (
   input  logic                            clk_16_8,
   input  logic                            system_reset,
   input  gps_panel_pkg::hex_frame_t       frame,
   output gps_panel_pkg::seg_t       [7:0] hex
);

   // Segment order g f e d c b a, a lit segment is 0
   function automatic gps_panel_pkg::seg_t seg_of(input gps_panel_pkg::nibble_t value);
      case (value)
         4'h0:    seg_of = 7'b1000000;
         4'h1:    seg_of = 7'b1111001;
         4'h2:    seg_of = 7'b0100100;
         4'h3:    seg_of = 7'b0110000;
         4'h4:    seg_of = 7'b0011001;
         4'h5:    seg_of = 7'b0010010;
         4'h6:    seg_of = 7'b0000010;
         4'h7:    seg_of = 7'b1111000;
         4'h8:    seg_of = 7'b0000000;
         4'h9:    seg_of = 7'b0010000;
         4'ha:    seg_of = 7'b0001000;
         4'hb:    seg_of = 7'b0000011;   // Lower case b
         4'hc:    seg_of = 7'b1000110;
         4'hd:    seg_of = 7'b0100001;   // Lower case d
         4'he:    seg_of = 7'b0000110;
         default: seg_of = 7'b0001110;
      endcase
   endfunction

   always_ff @(posedge clk_16_8) begin
      if (system_reset) begin
         hex <= '1;   // Blank
      end else begin
         for (int i = 0; i < 8; i++) begin
            hex[i] <= frame.enable[i] ? seg_of(frame.digit[i]) : 7'b1111111;
         end
      end
   end

endmodule

// ==== status_display_select.sv ====
`timescale 1ns/100ps
`include "gps_panel_defs.svh"

module status_display_select (
   input  logic                           clk_16_8,
   input  logic                           system_reset,
   input  gps_panel_pkg::switch_t         sw,
   input  gps_panel_pkg::feed_status_t    feed,
   input  gps_panel_pkg::channel_status_t chan,
   input  gps_panel_pkg::acq_result_t     acq,
   output logic [17:0]                    ledr,
   output logic [8:0]                     ledg,
   output gps_panel_pkg::hex_frame_t      frame
);

   logic disp_count;
   logic disp_acq;
   logic disp_acq_dopp;
   logic disp_acq_cs;
   logic disp_cs;

   gps_panel_pkg::acc_t          iq_sel;
   gps_panel_pkg::pkt_count_t    pkt_sel;
   gps_panel_pkg::sample_count_t count_sel;

   logic [17:0]               ledr_next;
   logic [8:0]                ledg_next;
   gps_panel_pkg::hex_frame_t frame_next;

   // Page decode, count page wins over everything
   assign disp_count    = sw[4];
   assign disp_acq      = !disp_count && sw[14];
   assign disp_acq_dopp = disp_acq && (sw[13:12] == 2'd1);
   assign disp_acq_cs   = disp_acq && (sw[13:12] == 2'd2);
   assign disp_cs       = !disp_count && !disp_acq && sw[15];

   always_comb begin
      if (sw[17]) begin
         iq_sel = sw[16] ? chan.acc_q : chan.acc_i;         // Accumulators
      end else begin
         iq_sel = sw[16] ? chan.q_prompt : chan.i_prompt;   // Prompt history
      end
   end

   assign pkt_sel   = sw[10] ? feed.good_pkt_count : feed.missed_count;
   assign count_sel = sw[3] ? chan.sample_count_sync : feed.sample_count;

   assign ledr_next = sw[11] ? 18'(pkt_sel) : 18'(iq_sel);
   assign ledg_next = {feed.link_status, 5'b0, acq.complete, feed.sample_valid, 1'b0};

   always_comb begin
      if (disp_count) begin
         frame_next.digit  = count_sel;
         frame_next.enable = 8'hff;
      end else if (disp_acq_dopp) begin
         frame_next.digit  = 32'(acq.peak_doppler);      // Sign bit on digit 4
         frame_next.enable = 8'h1f;
      end else if (disp_acq_cs) begin
         frame_next.digit  = 32'(acq.peak_code_shift);
         frame_next.enable = 8'h0f;
      end else if (disp_acq) begin
         frame_next.digit  = acq.peak_i2q2[`GP_I2Q2_W-1 -: 32];   // Top 32 bits of power
         frame_next.enable = 8'hff;
      end else if (disp_cs) begin
         frame_next.digit  = 32'(chan.code_shift);
         frame_next.enable = 8'h0f;
      end else begin
         frame_next.digit  = 32'(iq_sel);                // Bits 17:16 on digit 4
         frame_next.enable = 8'h1f;
      end
   end

   always_ff @(posedge clk_16_8) begin
      if (system_reset) begin
         ledr  <= '0;
         ledg  <= '0;
         frame <= '0;   // All digits disabled
      end else begin
         ledr  <= ledr_next;
         ledg  <= ledg_next;
         frame <= frame_next;
      end
   end

endmodule

// ==== tracking_ready_stretch.sv ====
`timescale 1ns/100ps
`include "gps_panel_defs.svh"

module tracking_ready_stretch (
   input  logic clk_16_8,
   input  logic system_reset,
   input  logic tracking_ready,
   input  logic mode_track,
   output logic ready_flag
);

   localparam int HOLD_W = $clog2(`GP_READY_HOLD + 1);

   logic [HOLD_W-1:0] hold_count;

   // Any ready pulse restarts the hold, only tracking mode raises the flag
   always_ff @(posedge clk_16_8) begin
      if (system_reset) begin
         hold_count <= '0;
         ready_flag <= 1'b0;
      end else begin
         if (tracking_ready) begin
            hold_count <= HOLD_W'(`GP_READY_HOLD);
         end else if (hold_count != '0) begin
            hold_count <= hold_count - 1'b1;
         end

         if (tracking_ready && mode_track) begin
            ready_flag <= 1'b1;
         end else if (!tracking_ready && hold_count == '0) begin
            ready_flag <= 1'b0;   // Hold expired
         end
      end
   end

endmodule

// ==== sample_clock_divider.sv ====
`timescale 1ns/100ps
`include "gps_panel_defs.svh"

module sample_clock_divider (
   input  logic clk_16_8,
   input  logic system_reset,
   output logic clk_sample
);

   localparam int DIV_W = $clog2(`GP_SAMPLE_DIV + 1);

   logic [DIV_W-1:0] div_count;

   always_ff @(posedge clk_16_8) begin
      if (system_reset) begin
         div_count  <= DIV_W'(`GP_SAMPLE_DIV);
         clk_sample <= 1'b0;
      end else if (div_count == '0) begin
         div_count  <= DIV_W'(`GP_SAMPLE_DIV);   // Reload
         clk_sample <= ~clk_sample;              // Half period done
      end else begin
         div_count  <= div_count - 1'b1;
      end
   end

endmodule

// ==== panel_reset.sv ====
`timescale 1ns/100ps
`include "gps_panel_defs.svh"

module panel_reset (
   input  logic clk_16_8,
   input  logic reset,
   input  logic pll_locked,
   input  logic key_n,
   output logic system_reset
);

   localparam int POR_W = $clog2(`GP_POR_CYCLES);

   gps_panel_pkg::por_state_e state;
   logic [POR_W-1:0]          por_count;

   always_ff @(posedge clk_16_8) begin
      if (reset) begin
         state        <= gps_panel_pkg::POR_HOLD;
         por_count    <= '0;
         system_reset <= 1'b1;
      end else begin
         case (state)
            gps_panel_pkg::POR_HOLD: begin
               por_count <= por_count + 1'b1;
               if (por_count == POR_W'(`GP_POR_CYCLES - 1)) begin
                  state <= gps_panel_pkg::POR_RUN;   // Hold time elapsed
               end
            end
            gps_panel_pkg::POR_RUN: begin
               por_count <= '0;
            end
            default: begin
               state <= gps_panel_pkg::POR_HOLD;
            end
         endcase
         // Any source holds the rest of the board in reset
         system_reset <= (state == gps_panel_pkg::POR_HOLD) | ~pll_locked | ~key_n;
      end
   end

endmodule

// ==== gps_panel_pkg.sv ====
`include "gps_panel_defs.svh"

package gps_panel_pkg;

   typedef logic [`GP_I2Q2_W-1:0]  i2q2_t;
   typedef logic [`GP_ACC_W-1:0]   acc_t;
   typedef logic [`GP_DOPP_W-1:0]  doppler_t;
   typedef logic [`GP_CS_W-1:0]    code_shift_t;
   typedef logic [`GP_PKT_W-1:0]   pkt_count_t;
   typedef logic [`GP_COUNT_W-1:0] sample_count_t;

   typedef logic [3:0]  nibble_t;   // One hex digit
   typedef logic [6:0]  seg_t;      // Segments g..a, active low
   typedef logic [17:0] switch_t;   // Board toggle switches

   // Ethernet sample feed status
   typedef struct packed {
      logic          link_status;
      logic          sample_valid;
      pkt_count_t    good_pkt_count;
      pkt_count_t    missed_count;
      sample_count_t sample_count;
   } feed_status_t;

   // Tracking channel history
   typedef struct packed {
      acc_t          i_prompt;
      acc_t          q_prompt;
      acc_t          acc_i;
      acc_t          acc_q;
      code_shift_t   code_shift;
      sample_count_t sample_count_sync;
   } channel_status_t;

   // Acquisition peak search result
   typedef struct packed {
      logic        complete;
      i2q2_t       peak_i2q2;
      doppler_t    peak_doppler;
      code_shift_t peak_code_shift;
   } acq_result_t;

   // Digit 7 is the leftmost display digit
   typedef struct packed {
      nibble_t [7:0] digit;
      logic    [7:0] enable;
   } hex_frame_t;

   typedef enum logic {
      POR_HOLD,
      POR_RUN
   } por_state_e;

endpackage

// ==== gps_panel_defs.svh ====
`ifndef GPS_PANEL_DEFS_SVH
`define GPS_PANEL_DEFS_SVH

// Sample clock divider reload, clk_sample toggles every reload+1 cycles
`define GP_SAMPLE_DIV 8

// Power-on hold after board reset
`define GP_POR_CYCLES 16

// Tracking-ready stretch counter reload, flag lasts reload+1 cycles
`define GP_READY_HOLD 15

// Receiver value widths
`define GP_I2Q2_W  38     // Correlator power
`define GP_ACC_W   18     // Accumulator and prompt I/Q
`define GP_DOPP_W  17     // Doppler phase increment
`define GP_CS_W    15     // Code shift
`define GP_PKT_W   9      // Packet counters
`define GP_COUNT_W 32     // Sample counters

`endif
